// ==== Makefile ====
# Verilator build and run for the rv32c expander testbench

TOP := tb_cdec

.PHONY: compile run clean

compile:
	verilator --binary -f project.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

# the run passes only if the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

// ==== dv/tb_cdec.sv ====
// directed testbench for the two-stage rv32c expander
// clock, reset, value checker, watchdog and one task per test
`timescale 1ns/1ps
`default_nettype none

module tb_cdec;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 5;
  // idle check, random words, q0, q1, q2 and the mixed stream
  localparam int NUM_VECTORS  = 51;

  logic         clk;
  logic         reset_i;
  logic         valid_i;
  logic [31:0]  instr_i;
  logic         valid_o;
  logic [31:0]  instr_o;
  logic         is_compressed_o;
  logic         illegal_o;

  integer seed = 5;
  int     checks = 0;
  int     errors = 0;

  cdec_top i_cdec_top (
    .clk             (clk),
    .reset_i         (reset_i),
    .valid_i         (valid_i),
    .instr_i         (instr_i),
    .valid_o         (valid_o),
    .instr_o         (instr_o),
    .is_compressed_o (is_compressed_o),
    .illegal_o       (illegal_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // up to 4 cycles per vector plus the reset cycles
  initial begin
    repeat (NUM_VECTORS * 4 + RESET_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles",
             NUM_VECTORS * 4 + RESET_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // checker and single-word driver
  ////////////////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  // strobe one word and expect the result exactly two edges later
  task automatic expand_and_check(input logic [31:0] word, input logic [31:0] exp_instr,
                                  input logic exp_compressed, input logic exp_illegal,
                                  input logic check_instr);
    @(negedge clk);
    valid_i = 1'b1;
    instr_i = word;
    @(negedge clk);
    valid_i = 1'b0;
    instr_i = 32'h0;
    // only the input stage holds the word here
    check_value("valid_o", 32'(valid_o), 32'd0);
    @(negedge clk);
    check_value("valid_o", 32'(valid_o), 32'd1);
    check_value("is_compressed_o", 32'(is_compressed_o), 32'(exp_compressed));
    check_value("illegal_o", 32'(illegal_o), 32'(exp_illegal));
    if (check_instr) begin
      check_value("instr_o", instr_o, exp_instr);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////
  task automatic idle_after_reset();
    repeat (4) begin
      @(negedge clk);
      check_value("valid_o", 32'(valid_o), 32'd0);
    end
  endtask

  task automatic full_word_passthrough();
    logic [31:0] word;
    for (int i = 0; i < 8; i++) begin
      word = $random(seed);
      word[1:0] = 2'b11;
      expand_and_check(word, word, 1'b0, 1'b0, 1'b1);
    end
  endtask

  task automatic quadrant0_vectors();
    // c.addi4spn x8,sp,4 and x9,sp,1020
    expand_and_check(32'h0000_0040, 32'h0041_0413, 1'b1, 1'b0, 1'b1);
    expand_and_check(32'h0000_1FE4, 32'h3FC1_0493, 1'b1, 1'b0, 1'b1);
    // c.lw and c.sw x10, 124(x11)
    expand_and_check(32'h0000_5DE8, 32'h07C5_A503, 1'b1, 1'b0, 1'b1);
    expand_and_check(32'h0000_DDE8, 32'h06A5_AE23, 1'b1, 1'b0, 1'b1);
    // all-zero word, c.flw
    expand_and_check(32'h0000_0000, 32'h0, 1'b1, 1'b1, 1'b0);
    expand_and_check(32'h0000_6000, 32'h0, 1'b1, 1'b1, 1'b0);
  endtask

  task automatic quadrant1_vectors();
    expand_and_check(32'h0000_0001, 32'h0000_0013, 1'b1, 1'b0, 1'b1);
    // addi a0,a0,-1
    expand_and_check(32'h0000_157D, 32'hFFF5_0513, 1'b1, 1'b0, 1'b1);
    // c.jal +1024, c.j -2
    expand_and_check(32'h0000_2101, 32'h4000_00EF, 1'b1, 1'b0, 1'b1);
    expand_and_check(32'h0000_BFFD, 32'hFFFF_F06F, 1'b1, 1'b0, 1'b1);
    // c.li x15,31 and c.lui x5,0xfffff
    expand_and_check(32'h0000_47FD, 32'h01F0_0793, 1'b1, 1'b0, 1'b1);
    expand_and_check(32'h0000_72FD, 32'hFFFF_F2B7, 1'b1, 1'b0, 1'b1);
    // c.addi16sp 96
    expand_and_check(32'h0000_6125, 32'h0601_0113, 1'b1, 1'b0, 1'b1);
    // srli x8,3 then srai x9,31 then andi x10,-8
    expand_and_check(32'h0000_800D, 32'h0034_5413, 1'b1, 1'b0, 1'b1);
    expand_and_check(32'h0000_84FD, 32'h41F4_D493, 1'b1, 1'b0, 1'b1);
    expand_and_check(32'h0000_9961, 32'hFF85_7513, 1'b1, 1'b0, 1'b1);
    // register-register group
    expand_and_check(32'h0000_8C05, 32'h4094_0433, 1'b1, 1'b0, 1'b1);
    expand_and_check(32'h0000_8C25, 32'h0094_4433, 1'b1, 1'b0, 1'b1);
    expand_and_check(32'h0000_8C45, 32'h0094_6433, 1'b1, 1'b0, 1'b1);
    expand_and_check(32'h0000_8FF9, 32'h00E7_F7B3, 1'b1, 1'b0, 1'b1);
    // beqz x8,+8 and bnez x9,-2
    expand_and_check(32'h0000_C401, 32'h0004_0463, 1'b1, 1'b0, 1'b1);
    expand_and_check(32'h0000_FCFD, 32'hFE04_9FE3, 1'b1, 1'b0, 1'b1);
    // lui zero imm, subw, zext.b
    expand_and_check(32'h0000_6281, 32'h0, 1'b1, 1'b1, 1'b0);
    expand_and_check(32'h0000_9C05, 32'h0, 1'b1, 1'b1, 1'b0);
    expand_and_check(32'h0000_9C61, 32'h0, 1'b1, 1'b1, 1'b0);
  endtask

  task automatic quadrant2_vectors();
    expand_and_check(32'h0000_0512, 32'h0045_1513, 1'b1, 1'b0, 1'b1);
    // lw ra,12(sp) then ret
    expand_and_check(32'h0000_40B2, 32'h00C1_2083, 1'b1, 1'b0, 1'b1);
    expand_and_check(32'h0000_8082, 32'h0000_8067, 1'b1, 1'b0, 1'b1);
    // mv a0,a1 then add a0,a0,a1
    expand_and_check(32'h0000_852E, 32'h00B0_0533, 1'b1, 1'b0, 1'b1);
    expand_and_check(32'h0000_952E, 32'h00B5_0533, 1'b1, 1'b0, 1'b1);
    expand_and_check(32'h0000_9282, 32'h0002_80E7, 1'b1, 1'b0, 1'b1);
    // sw ra,12(sp)
    expand_and_check(32'h0000_C606, 32'h0011_2623, 1'b1, 1'b0, 1'b1);
    expand_and_check(32'h0000_9002, cdec_pkg::EBREAK_WORD, 1'b1, 1'b0, 1'b1);
    // lwsp x0, jr x0, fswsp
    expand_and_check(32'h0000_4002, 32'h0, 1'b1, 1'b1, 1'b0);
    expand_and_check(32'h0000_8002, 32'h0, 1'b1, 1'b1, 1'b0);
    expand_and_check(32'h0000_E002, 32'h0, 1'b1, 1'b1, 1'b0);
  endtask

  // two strobes back to back and then one empty cycle
  task automatic mixed_stream();
    logic [31:0] words [6];
    logic [31:0] exp_instr [6];
    logic        exp_compressed [6];
    logic        exp_illegal [6];
    int          sent_cycle [6];
    int          sent;
    int          seen;
    words = '{32'h0000_0001, 32'hDEAD_BEEF, 32'h0000_8082,
              32'h0000_0000, 32'h0000_157D, 32'h0000_9002};
    exp_instr = '{32'h0000_0013, 32'hDEAD_BEEF, 32'h0000_8067,
                  32'h0, 32'hFFF5_0513, cdec_pkg::EBREAK_WORD};
    exp_compressed = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1};
    exp_illegal = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
    sent = 0;
    seen = 0;
    for (int cycle = 0; cycle < 14; cycle++) begin
      @(negedge clk);
      // outputs settled at the last rising edge
      if (valid_o && seen >= 6) begin
        errors++;
        $display("valid_o pulsed with no word in flight");
      end else if (valid_o) begin
        check_value("latency", 32'(cycle - sent_cycle[seen]), 32'd2);
        check_value("is_compressed_o", 32'(is_compressed_o),
                    32'(exp_compressed[seen]));
        check_value("illegal_o", 32'(illegal_o), 32'(exp_illegal[seen]));
        // the all-zero word has no defined result to compare
        if (!exp_illegal[seen]) begin
          check_value("instr_o", instr_o, exp_instr[seen]);
        end
        seen++;
      end
      if (sent < 6 && (cycle % 3) != 2) begin
        valid_i          = 1'b1;
        instr_i          = words[sent];
        sent_cycle[sent] = cycle;
        sent++;
      end else begin
        valid_i = 1'b0;
        instr_i = 32'h0;
      end
    end
    check_value("words out", 32'(seen), 32'd6);
  endtask

  ////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////
  initial begin
    reset_i = 1'b1;
    valid_i = 1'b0;
    instr_i = 32'h0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset_i = 1'b0;
    idle_after_reset();
    full_word_passthrough();
    quadrant0_vectors();
    quadrant1_vectors();
    quadrant2_vectors();
    mixed_stream();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
src/cdec_pkg.sv
src/cdec_stage_if.sv
src/cdec_input_stage.sv
src/cdec_q0_expand.sv
src/cdec_q1_expand.sv
src/cdec_q2_expand.sv
src/cdec_expand_stage.sv
src/cdec_top.sv
dv/tb_cdec.sv

// ==== src/cdec_expand_stage.sv ====
// expand stage, quadrant select and output registers
`timescale 1ns/1ps
`default_nettype none

module cdec_expand_stage (
  input  logic                          clk,
  input  logic                          reset_i,
  cdec_stage_if.consumer                in_i,
  output logic                          valid_o,
  output logic [cdec_pkg::INSTR_W-1:0]  instr_o,
  output logic                          is_compressed_o,
  output logic                          illegal_o
);

  logic [cdec_pkg::CINSTR_W-1:0]  cinstr;
  logic [cdec_pkg::INSTR_W-1:0]   q0_instr;
  logic [cdec_pkg::INSTR_W-1:0]   q1_instr;
  logic [cdec_pkg::INSTR_W-1:0]   q2_instr;
  logic [cdec_pkg::INSTR_W-1:0]   instr_d;
  logic                           q0_illegal;
  logic                           q1_illegal;
  logic                           q2_illegal;
  logic                           illegal_d;

  // all three expanders see the low half in parallel
  assign cinstr = in_i.instr[cdec_pkg::CINSTR_W-1:0];

  cdec_q0_expand i_q0_expand (.cinstr_i(cinstr), .instr_o(q0_instr), .illegal_o(q0_illegal));
  cdec_q1_expand i_q1_expand (.cinstr_i(cinstr), .instr_o(q1_instr), .illegal_o(q1_illegal));
  cdec_q2_expand i_q2_expand (.cinstr_i(cinstr), .instr_o(q2_instr), .illegal_o(q2_illegal));

  ////////////////////////////////////////////////////////////
  // quadrant select
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (in_i.quadrant)
      cdec_pkg::Q0: {instr_d, illegal_d} = {q0_instr, q0_illegal};
      cdec_pkg::Q1: {instr_d, illegal_d} = {q1_instr, q1_illegal};
      cdec_pkg::Q2: {instr_d, illegal_d} = {q2_instr, q2_illegal};
      // 32-bit word passes through as fetched
      default:      {instr_d, illegal_d} = {in_i.instr, 1'b0};
    endcase
  end

  // output strobe, one pulse per accepted word
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= in_i.valid;
    end
  end

  // result registers load with the strobe, hold between words
  always_ff @(posedge clk) begin
    if (in_i.valid) begin
      instr_o         <= instr_d;
      is_compressed_o <= in_i.is_compressed;
      illegal_o       <= illegal_d;
    end
  end

endmodule

`default_nettype wire

// ==== src/cdec_input_stage.sv ====
// input stage, registers the strobed fetch word and classifies it
`timescale 1ns/1ps
`default_nettype none

module cdec_input_stage (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic                          valid_i,
  input  logic [cdec_pkg::INSTR_W-1:0]  instr_i,
  cdec_stage_if.producer                out_o
);

  logic                          valid_q;
  logic [cdec_pkg::INSTR_W-1:0]  instr_q;
  cdec_pkg::quadrant_e           quadrant;

  // strobe register, the only control state here
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  // word register, loads on the strobe and holds otherwise
  always_ff @(posedge clk) begin
    if (valid_i) begin
      instr_q <= instr_i;
    end
  end

  // all four codes of the low bits are defined quadrants
  assign quadrant = cdec_pkg::quadrant_e'(instr_q[1:0]);

  // drive the stage link
  assign out_o.valid         = valid_q;
  assign out_o.instr         = instr_q;
  assign out_o.quadrant      = quadrant;
  // 11 in the low bits is the only 32-bit form
  assign out_o.is_compressed = (quadrant != cdec_pkg::FULL);

endmodule

`default_nettype wire

// ==== src/cdec_pkg.sv ====
// shared types for the compressed expander
// opcode and quadrant enums, widths, register numbers, fixed words
`default_nettype none

package cdec_pkg;

  // fetch word and expanded word width
  localparam int unsigned INSTR_W  = 32;
  // compressed instruction width
  localparam int unsigned CINSTR_W = 16;

  ////////////////////////////////////////////////////////////
  // rv32 major opcodes produced by the expansions
  ////////////////////////////////////////////////////////////
  typedef enum logic [6:0] {
    LOAD   = 7'b000_0011,
    STORE  = 7'b010_0011,
    OP_IMM = 7'b001_0011,
    OP     = 7'b011_0011,
    LUI    = 7'b011_0111,
    BRANCH = 7'b110_0011,
    JAL    = 7'b110_1111,
    JALR   = 7'b110_0111,
    SYSTEM = 7'b111_0011
  } opcode_e;

  // low two bits of a fetch word
  // full marks an uncompressed 32-bit instruction
  typedef enum logic [1:0] {
    Q0   = 2'b00,
    Q1   = 2'b01,
    Q2   = 2'b10,
    FULL = 2'b11
  } quadrant_e;

  // fixed register numbers used by the expansions
  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;
  localparam logic [4:0] REG_SP   = 5'd2;

  // upper bits of a 3-bit register field, giving x8 to x15
  localparam logic [1:0] PRIME_PREFIX = 2'b01;

  // ebreak, imm 1 with the system opcode
  localparam logic [INSTR_W-1:0] EBREAK_WORD = {12'h001, 13'h0000, SYSTEM};

endpackage

`default_nettype wire

// ==== src/cdec_q0_expand.sv ====
// quadrant 0 expansion: c.addi4spn, c.lw, c.sw
`timescale 1ns/1ps
`default_nettype none

module cdec_q0_expand (
  input  logic [cdec_pkg::CINSTR_W-1:0]  cinstr_i,
  output logic [cdec_pkg::INSTR_W-1:0]   instr_o,
  output logic                           illegal_o
);

  logic [2:0]                    funct3;
  logic [4:0]                    rd_p;
  logic [4:0]                    rs1_p;
  logic [cdec_pkg::INSTR_W-1:0]  lw_word;

  assign funct3 = cinstr_i[15:13];

  // prime registers x8..x15
  // rd' doubles as rs2' for c.sw
  assign rd_p  = {cdec_pkg::PRIME_PREFIX, cinstr_i[4:2]};
  assign rs1_p = {cdec_pkg::PRIME_PREFIX, cinstr_i[9:7]};

  // lw rd', uimm(rs1'), uimm[6|5:3|2] scattered over bits 5, 12:10, 6
  // also the base word for every illegal code
  assign lw_word = {5'b0, cinstr_i[5], cinstr_i[12:10], cinstr_i[6], 2'b00,
                    rs1_p, 3'b010, rd_p, cdec_pkg::LOAD};

  always_comb begin
    instr_o   = lw_word;
    illegal_o = 1'b0;
    case (funct3)
      3'b000: begin
        // c.addi4spn -> addi rd', sp, nzuimm
        // nzuimm[9:2] comes from bits 10:7, 12:11, 5, 6
        instr_o = {2'b0, cinstr_i[10:7], cinstr_i[12:11], cinstr_i[5], cinstr_i[6],
                   2'b00, cdec_pkg::REG_SP, 3'b000, rd_p, cdec_pkg::OP_IMM};
        // zero immediate is reserved, this covers the all-zero word
        illegal_o = (cinstr_i[12:5] == 8'b0);
      end
      3'b010: begin
        // c.lw
        instr_o = lw_word;
      end
      3'b110: begin
        // c.sw -> sw rs2', uimm(rs1'), store splits the offset at bit 5
        instr_o = {5'b0, cinstr_i[5], cinstr_i[12], rd_p, rs1_p, 3'b010,
                   cinstr_i[11:10], cinstr_i[6], 2'b00, cdec_pkg::STORE};
      end
      default: begin
        // float loads and stores, zc byte and half forms, reserved
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/cdec_q1_expand.sv ====
// quadrant 1 expansion: immediates, arithmetic on prime registers,
// jumps and compare-to-zero branches
`timescale 1ns/1ps
`default_nettype none

module cdec_q1_expand (
  input  logic [cdec_pkg::CINSTR_W-1:0]  cinstr_i,
  output logic [cdec_pkg::INSTR_W-1:0]   instr_o,
  output logic                           illegal_o
);

  logic [2:0]   funct3;
  logic [4:0]   rd;
  logic [4:0]   rd_p;
  logic [4:0]   rs2_p;
  logic [11:0]  imm6_sext;
  logic [11:0]  imm16sp;
  logic [19:0]  jal_imm;
  logic [4:0]   jal_rd;

  assign funct3 = cinstr_i[15:13];
  // full register field, also rs1 for addi
  assign rd     = cinstr_i[11:7];
  // prime fields for the arithmetic and branch groups
  assign rd_p   = {cdec_pkg::PRIME_PREFIX, cinstr_i[9:7]};
  assign rs2_p  = {cdec_pkg::PRIME_PREFIX, cinstr_i[4:2]};

  // 6-bit immediate, sign at bit 12
  assign imm6_sext = {{7{cinstr_i[12]}}, cinstr_i[6:2]};

  // addi16sp nzimm[9:4], bit order 9, 8:7, 6, 5, 4
  assign imm16sp = {{3{cinstr_i[12]}}, cinstr_i[4:3], cinstr_i[5], cinstr_i[2],
                    cinstr_i[6], 4'b0000};

  // jal immediate field, imm[20|10:1|11|19:12]
  assign jal_imm = {cinstr_i[12], cinstr_i[8], cinstr_i[10:9], cinstr_i[6],
                    cinstr_i[7], cinstr_i[2], cinstr_i[11], cinstr_i[5:3],
                    {9{cinstr_i[12]}}};

  // c.jal links to ra, c.j discards the link
  assign jal_rd = cinstr_i[15] ? cdec_pkg::REG_ZERO : cdec_pkg::REG_RA;

  always_comb begin
    instr_o   = {imm6_sext, rd, 3'b000, rd, cdec_pkg::OP_IMM};
    illegal_o = 1'b0;
    case (funct3)
      3'b000: begin
        // c.addi and c.nop -> addi rd, rd, imm
        instr_o = {imm6_sext, rd, 3'b000, rd, cdec_pkg::OP_IMM};
      end
      3'b001, 3'b101: begin
        // c.jal, c.j
        instr_o = {jal_imm, jal_rd, cdec_pkg::JAL};
      end
      3'b010: begin
        // c.li -> addi rd, x0, imm, rd of x0 is a hint
        instr_o = {imm6_sext, cdec_pkg::REG_ZERO, 3'b000, rd, cdec_pkg::OP_IMM};
      end
      3'b011: begin
        if (rd == cdec_pkg::REG_SP) begin
          // c.addi16sp -> addi sp, sp, nzimm
          instr_o = {imm16sp, cdec_pkg::REG_SP, 3'b000, cdec_pkg::REG_SP, cdec_pkg::OP_IMM};
        end else begin
          // c.lui -> lui rd, nzimm, rd of x0 is a hint
          instr_o = {{15{cinstr_i[12]}}, cinstr_i[6:2], rd, cdec_pkg::LUI};
        end
        // zero immediate reserved for both forms
        illegal_o = ({cinstr_i[12], cinstr_i[6:2]} == 6'b0);
      end
      3'b100: begin
        case (cinstr_i[11:10])
          2'b00, 2'b01: begin
            // c.srli, c.srai, bit 10 picks the arithmetic form
            instr_o = {1'b0, cinstr_i[10], 5'b0, cinstr_i[6:2], rd_p, 3'b101,
                       rd_p, cdec_pkg::OP_IMM};
            // shamt[5] only exists on rv64
            illegal_o = cinstr_i[12];
          end
          2'b10: begin
            // c.andi
            instr_o = {imm6_sext, rd_p, 3'b111, rd_p, cdec_pkg::OP_IMM};
          end
          default: begin
            // register-register group selected by bits 12, 6:5
            case ({cinstr_i[12], cinstr_i[6:5]})
              3'b000:  instr_o = {7'b0100000, rs2_p, rd_p, 3'b000, rd_p, cdec_pkg::OP};
              3'b001:  instr_o = {7'b0000000, rs2_p, rd_p, 3'b100, rd_p, cdec_pkg::OP};
              3'b010:  instr_o = {7'b0000000, rs2_p, rd_p, 3'b110, rd_p, cdec_pkg::OP};
              default: begin
                // c.and, and the and form as base for subw, addw and zc
                instr_o   = {7'b0000000, rs2_p, rd_p, 3'b111, rd_p, cdec_pkg::OP};
                illegal_o = cinstr_i[12];
              end
            endcase
          end
        endcase
      end
      default: begin
        // c.beqz, c.bnez -> beq/bne rs1', x0, imm, bit 13 picks bne
        instr_o = {{4{cinstr_i[12]}}, cinstr_i[6:5], cinstr_i[2], cdec_pkg::REG_ZERO,
                   rd_p, 2'b00, cinstr_i[13], cinstr_i[11:10], cinstr_i[4:3],
                   cinstr_i[12], cdec_pkg::BRANCH};
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/cdec_q2_expand.sv ====
// quadrant 2 expansion: slli, stack loads and stores,
// jr/jalr, mv/add and ebreak
`timescale 1ns/1ps
`default_nettype none

module cdec_q2_expand (
  input  logic [cdec_pkg::CINSTR_W-1:0]  cinstr_i,
  output logic [cdec_pkg::INSTR_W-1:0]   instr_o,
  output logic                           illegal_o
);

  logic [2:0]                    funct3;
  logic [4:0]                    rd;
  logic [4:0]                    rs2;
  logic [cdec_pkg::INSTR_W-1:0]  lwsp_word;

  assign funct3 = cinstr_i[15:13];
  assign rd     = cinstr_i[11:7];
  assign rs2    = cinstr_i[6:2];

  // lw rd, uimm(sp), uimm[7:6|5|4:2] from bits 3:2, 12, 6:4
  // base word for the float stack forms as well
  assign lwsp_word = {4'b0, cinstr_i[3:2], cinstr_i[12], cinstr_i[6:4], 2'b00,
                      cdec_pkg::REG_SP, 3'b010, rd, cdec_pkg::LOAD};

  always_comb begin
    instr_o   = lwsp_word;
    illegal_o = 1'b0;
    case (funct3)
      3'b000: begin
        // c.slli, rd or shamt of zero are hints
        instr_o   = {7'b0, rs2, rd, 3'b001, rd, cdec_pkg::OP_IMM};
        // shamt[5] is rv64 only
        illegal_o = cinstr_i[12];
      end
      3'b010: begin
        // c.lwsp, loading into x0 is reserved
        instr_o   = lwsp_word;
        illegal_o = (rd == cdec_pkg::REG_ZERO);
      end
      3'b100: begin
        if (rs2 == cdec_pkg::REG_ZERO) begin
          if (!cinstr_i[12] && (rd == cdec_pkg::REG_ZERO)) begin
            // jr x0 is reserved
            // op format so jump decoding downstream never sees it
            instr_o   = {7'b0, rs2, cdec_pkg::REG_ZERO, 3'b000, rd, cdec_pkg::OP};
            illegal_o = 1'b1;
          end else if (!cinstr_i[12]) begin
            // c.jr -> jalr x0, 0(rs1)
            instr_o = {12'b0, rd, 3'b000, cdec_pkg::REG_ZERO, cdec_pkg::JALR};
          end else if (rd == cdec_pkg::REG_ZERO) begin
            // c.ebreak
            instr_o = cdec_pkg::EBREAK_WORD;
          end else begin
            // c.jalr -> jalr ra, 0(rs1)
            instr_o = {12'b0, rd, 3'b000, cdec_pkg::REG_RA, cdec_pkg::JALR};
          end
        end else if (!cinstr_i[12]) begin
          // c.mv -> add rd, x0, rs2, rd of x0 is a hint
          instr_o = {7'b0, rs2, cdec_pkg::REG_ZERO, 3'b000, rd, cdec_pkg::OP};
        end else begin
          // c.add -> add rd, rd, rs2
          instr_o = {7'b0, rs2, rd, 3'b000, rd, cdec_pkg::OP};
        end
      end
      3'b110: begin
        // c.swsp -> sw rs2, uimm(sp), uimm[7:6|5:2] from bits 8:7, 12:9
        instr_o = {4'b0, cinstr_i[8:7], cinstr_i[12], rs2, cdec_pkg::REG_SP, 3'b010,
                   cinstr_i[11:9], 2'b00, cdec_pkg::STORE};
      end
      default: begin
        // float stack forms and rv64 stack forms
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/cdec_stage_if.sv ====
// stage link carrying a classified fetch word
`timescale 1ns/1ps
`default_nettype none

interface cdec_stage_if;

  // one-cycle strobe, the fields below hold while it is high
  logic                          valid;
  // registered fetch word, upper half unused for compressed words
  logic [cdec_pkg::INSTR_W-1:0]  instr;
  // quadrant taken from the low two bits
  cdec_pkg::quadrant_e           quadrant;
  // set for every quadrant except full
  logic                          is_compressed;

  // input stage side
  modport producer (
    output valid,
    output instr,
    output quadrant,
    output is_compressed
  );

  // expand stage side
  modport consumer (
    input valid,
    input instr,
    input quadrant,
    input is_compressed
  );

endinterface

`default_nettype wire

// ==== src/cdec_top.sv ====
// top level of the two-stage rv32c expander
// input stage and expand stage joined by one stage link
`timescale 1ns/1ps
`default_nettype none

module cdec_top (
  input  logic                          clk,
  input  logic                          reset_i,
  // single-cycle fetch strobe, no back-pressure
  input  logic                          valid_i,
  input  logic [cdec_pkg::INSTR_W-1:0]  instr_i,
  // result two edges after the strobe
  output logic                          valid_o,
  output logic [cdec_pkg::INSTR_W-1:0]  instr_o,
  output logic                          is_compressed_o,
  output logic                          illegal_o
);

  ////////////////////////////////////////////////////////////
  // stage link
  ////////////////////////////////////////////////////////////
  cdec_stage_if stage_if ();

  // first edge, capture and classify
  cdec_input_stage i_input_stage (
    .clk     (clk),
    .reset_i (reset_i),
    .valid_i (valid_i),
    .instr_i (instr_i),
    .out_o   (stage_if.producer)
  );

  ////////////////////////////////////////////////////////////
  // second edge, expand and register the result
  ////////////////////////////////////////////////////////////
  cdec_expand_stage i_expand_stage (
    .clk             (clk),
    .reset_i         (reset_i),
    .in_i            (stage_if.consumer),
    .valid_o         (valid_o),
    .instr_o         (instr_o),
    .is_compressed_o (is_compressed_o),
    .illegal_o       (illegal_o)
  );

endmodule

`default_nettype wire
